// ==== alu.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module alu (
    input  exe_pkg::alu_op_t alu_op,
    input  exe_pkg::word_t   alu_src1,
    input  exe_pkg::word_t   alu_src2,
    output exe_pkg::word_t   alu_result,
    output logic             alu_ov
);
    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;

    logic          op_add;
    logic          op_sub;
    logic          op_slt;
    logic          op_sltu;
    logic          op_and;
    logic          op_nor;
    logic          op_or;
    logic          op_xor;
    logic          op_sll;
    logic          op_srl;
    logic          op_sra;
    logic          op_lui;
    logic          adder_sub;
    word_t         adder_b;
    logic [W:0]    adder_sum;      // top bit is carry out
    word_t         slt_result;
    word_t         sltu_result;
    word_t         sra_result;
    logic [4:0]    shamt;

    // bit order: add sub slt sltu and nor or xor sll srl sra lui
    assign op_add  = alu_op[0];
    assign op_sub  = alu_op[1];
    assign op_slt  = alu_op[2];
    assign op_sltu = alu_op[3];
    assign op_and  = alu_op[4];
    assign op_nor  = alu_op[5];
    assign op_or   = alu_op[6];
    assign op_xor  = alu_op[7];
    assign op_sll  = alu_op[8];
    assign op_srl  = alu_op[9];
    assign op_sra  = alu_op[10];
    assign op_lui  = alu_op[11];

    // one adder serves add, sub and both compares
    assign adder_sub = op_sub | op_slt | op_sltu;
    assign adder_b   = adder_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {{W{1'b0}}, adder_sub};

    assign slt_result  = {{(W-1){1'b0}},
                          (alu_src1[W-1] & ~alu_src2[W-1])
                          | (~(alu_src1[W-1] ^ alu_src2[W-1]) & adder_sum[W-1])};
    assign sltu_result = {{(W-1){1'b0}}, ~adder_sum[W]};

    assign shamt      = alu_src1[4:0];   // src1 holds the shift amount
    assign sra_result = $signed(alu_src2) >>> shamt;

    assign alu_result = ({W{op_add | op_sub}} & adder_sum[W-1:0])
                      | ({W{op_slt}}          & slt_result)
                      | ({W{op_sltu}}         & sltu_result)
                      | ({W{op_and}}          & (alu_src1 & alu_src2))
                      | ({W{op_nor}}          & ~(alu_src1 | alu_src2))
                      | ({W{op_or}}           & (alu_src1 | alu_src2))
                      | ({W{op_xor}}          & (alu_src1 ^ alu_src2))
                      | ({W{op_sll}}          & (alu_src2 << shamt))
                      | ({W{op_srl}}          & (alu_src2 >> shamt))
                      | ({W{op_sra}}          & sra_result)
                      | ({W{op_lui}}          & {alu_src2[15:0], 16'b0});

    // operands agree in sign but the sum does not
    assign alu_ov = (op_add | op_sub)
                  & (alu_src1[W-1] == adder_b[W-1])
                  & (adder_sum[W-1] != alu_src1[W-1]);

    // decode must never select two operations at once
    always_comb begin
        if (!$isunknown(alu_op)) begin
            assert ($onehot0(alu_op))
                else $error("alu_op is not one-hot: %b", alu_op);
        end
    end

endmodule

// ==== divider.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module divider (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            div_signed,
    input  exe_pkg::word_t  dividend,
    input  exe_pkg::word_t  divisor,
    input  logic            div_in_valid,
    input  logic            div_out_ready,
    output logic            div_out_valid,
    output exe_pkg::dword_t div_result
);
    import exe_pkg::*;

    localparam int W     = `EXE_WORD_W;
    localparam int CNT_W = $clog2(`EXE_DIV_CYCLES) + 1;

    div_state_t       state;
    logic [CNT_W-1:0] count;
    word_t            quo;            // dividend shifts out as quotient shifts in
    word_t            rem;
    word_t            dsr;
    logic             quo_neg;
    logic             rem_neg;
    word_t            dividend_abs;
    word_t            divisor_abs;
    logic [W:0]       rem_shift;
    logic [W+1:0]     trial;
    word_t            quo_fix;
    word_t            rem_fix;

    assign dividend_abs = (div_signed && dividend[W-1]) ? -dividend : dividend;
    assign divisor_abs  = (div_signed && divisor[W-1])  ? -divisor  : divisor;

    assign rem_shift = {rem, quo[W-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, dsr};   // msb set means restore

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (div_in_valid) state <= RUN;
                RUN:     if (count == CNT_W'(`EXE_DIV_CYCLES - 1)) state <= DONE;
                DONE:    if (div_out_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && div_in_valid) begin
            quo     <= dividend_abs;
            rem     <= '0;
            dsr     <= divisor_abs;
            count   <= '0;
            quo_neg <= div_signed && (dividend[W-1] ^ divisor[W-1]);
            rem_neg <= div_signed && dividend[W-1];   // remainder follows dividend
        end else if (state == RUN) begin
            count <= count + 1'b1;
            if (trial[W+1]) begin
                rem <= rem_shift[W-1:0];
                quo <= {quo[W-2:0], 1'b0};
            end else begin
                rem <= trial[W-1:0];
                quo <= {quo[W-2:0], 1'b1};
            end
        end
    end

    assign quo_fix = quo_neg ? -quo : quo;
    assign rem_fix = rem_neg ? -rem : rem;

    assign div_out_valid = (state == DONE);
    assign div_result    = {rem_fix, quo_fix};

    // the stage issues each divide once and waits for it
    assert property (@(posedge clk) disable iff (reset)
        state == RUN |-> !div_in_valid);

    assert property (@(posedge clk) disable iff (reset || flush)
        div_out_valid && !div_out_ready |=> div_out_valid);

endmodule

// ==== exe_checker.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module exe_checker (
    input  logic              clk,
    input  logic              reset,
    input  logic              es_to_ms_valid,
    input  logic              ms_allowin,
    input  exe_pkg::word_t    es_result,
    input  exe_pkg::reg_idx_t es_dest,
    input  logic              es_gr_we,
    input  logic              es_ov,
    input  logic              es_ades,
    input  logic              data_sram_req,
    input  logic              data_sram_wr,
    input  logic [3:0]        data_sram_wen,
    input  exe_pkg::word_t    data_sram_addr,
    input  exe_pkg::word_t    data_sram_wdata,
    input  logic              data_sram_addr_ok,
    output logic              done,
    output int                error_count,
    output int                item_count,
    output int                req_count
);
    import exe_pkg::*;

    localparam int FIELDS    = 16;
    localparam int MAX_LINES = 64;

    logic [31:0] expect_mem [0:MAX_LINES*FIELDS-1];
    int          n_lines;

    initial begin
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            expect_mem[i] = 32'h8000_0000 | i;   // bit 31 marks an unused slot
        end
        $readmemh("exe_input.txt", expect_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && !expect_mem[n_lines*FIELDS][31]) begin
            n_lines++;
        end
        error_count = 0;
        item_count  = 0;
        req_count   = 0;
    end

    assign done = (n_lines > 0) && (item_count == n_lines);

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: item %0d %s is %h, expected %h",
                     $time, item_count, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_handoff(input int k);
        logic [31:0] st;
        logic [31:0] exp_ov;
        logic [31:0] exp_ades;
        logic [31:0] exp_wen;
        logic        want_req;
        logic        got_req;
        st       = expect_mem[k*FIELDS+2];
        exp_ov   = expect_mem[k*FIELDS+12];
        exp_ades = expect_mem[k*FIELDS+13];
        exp_wen  = expect_mem[k*FIELDS+14];
        if (expect_mem[k*FIELDS+10] != 32'd0) begin
            compare_word("result", es_result, expect_mem[k*FIELDS+11]);
        end
        compare_word("dest", word_t'(es_dest), expect_mem[k*FIELDS+6]);
        compare_word("gr_we", word_t'(es_gr_we), expect_mem[k*FIELDS+5]);
        compare_word("ov", word_t'(es_ov), exp_ov);
        compare_word("ades", word_t'(es_ades), exp_ades);

        // clean memory ops go out on the bus exactly once
        want_req = (st != 32'd0) && (exp_ov == 32'd0) && (exp_ades == 32'd0);
        got_req  = data_sram_req && data_sram_addr_ok;
        if (want_req && !got_req) begin
            $display("Error at %0t: item %0d left without its memory request", $time, k);
            error_count++;
        end else if (!want_req && got_req) begin
            $display("Error at %0t: item %0d issued a memory request it should not", $time, k);
            error_count++;
        end else if (got_req) begin
            compare_word("addr", data_sram_addr, expect_mem[k*FIELDS+11]);
            compare_word("wen", word_t'(data_sram_wen), exp_wen);
            compare_word("wr", word_t'(data_sram_wr), word_t'(st != 32'd4));
            if (exp_wen != 32'd0) begin
                compare_word("wdata", data_sram_wdata, expect_mem[k*FIELDS+15]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (data_sram_req && data_sram_addr_ok) begin
                req_count <= req_count + 1;
                if (!(es_to_ms_valid && ms_allowin)) begin
                    $display("Error at %0t: memory request accepted with no hand-off", $time);
                    error_count++;
                end
            end
            if (es_to_ms_valid && ms_allowin) begin
                if (item_count >= n_lines) begin
                    $display("Error at %0t: extra item handed to memory", $time);
                    error_count++;
                end else begin
                    check_handoff(item_count);
                end
                item_count <= item_count + 1;
            end
        end
    end

endmodule

// ==== exe_input.txt ====
// alu md st imm ovc we dst imm rs rt chk result ov ades wen wdata, all hex
// alu is the one-hot select, md/st are enum codes, chk 0 skips the result compare
001 0 0 0 1 1 08 0000 00000005 00000003 1 00000008 0 0 0 00000000
001 0 0 0 1 1 09 0000 7fffffff 00000001 1 80000000 1 0 0 00000000
001 0 0 0 0 1 0a 0000 7fffffff 00000001 1 80000000 0 0 0 00000000
002 0 0 0 1 1 0b 0000 80000000 00000001 1 7fffffff 1 0 0 00000000
001 0 0 1 1 1 0c fff0 00000010 00000000 1 00000000 0 0 0 00000000
004 0 0 0 0 1 0d 0000 ffffffff 00000001 1 00000001 0 0 0 00000000
008 0 0 0 0 1 0e 0000 ffffffff 00000001 1 00000000 0 0 0 00000000
010 0 0 0 0 1 0f 0000 f0f0f0f0 ff00ff00 1 f000f000 0 0 0 00000000
020 0 0 0 0 1 10 0000 f0f0f0f0 ff00ff00 1 000f000f 0 0 0 00000000
040 0 0 1 0 1 11 5678 12340000 00000000 1 12345678 0 0 0 00000000
080 0 0 0 0 1 12 0000 f0f0f0f0 ff00ff00 1 0ff00ff0 0 0 0 00000000
100 0 0 0 0 1 13 0000 00000004 0000000f 1 000000f0 0 0 0 00000000
200 0 0 0 0 1 14 0000 00000004 80000000 1 08000000 0 0 0 00000000
400 0 0 0 0 1 15 0000 00000004 80000000 1 f8000000 0 0 0 00000000
800 0 0 1 0 1 16 abcd 00000000 00000000 1 abcd0000 0 0 0 00000000
000 1 0 0 0 0 00 0000 fffffffe 00000003 0 00000000 0 0 0 00000000
000 7 0 0 0 1 02 0000 00000000 00000000 1 ffffffff 0 0 0 00000000
000 8 0 0 0 1 03 0000 00000000 00000000 1 fffffffa 0 0 0 00000000
000 2 0 0 0 0 00 0000 fffffffe 00000003 0 00000000 0 0 0 00000000
000 7 0 0 0 1 02 0000 00000000 00000000 1 00000002 0 0 0 00000000
000 8 0 0 0 1 03 0000 00000000 00000000 1 fffffffa 0 0 0 00000000
000 3 0 0 0 0 00 0000 fffffff9 00000002 0 00000000 0 0 0 00000000
000 8 0 0 0 1 04 0000 00000000 00000000 1 fffffffd 0 0 0 00000000
000 7 0 0 0 1 05 0000 00000000 00000000 1 ffffffff 0 0 0 00000000
000 4 0 0 0 0 00 0000 00000064 00000007 0 00000000 0 0 0 00000000
000 7 0 0 0 1 06 0000 00000000 00000000 1 00000002 0 0 0 00000000
000 8 0 0 0 1 07 0000 00000000 00000000 1 0000000e 0 0 0 00000000
000 3 0 0 0 0 00 0000 00000007 fffffffe 0 00000000 0 0 0 00000000
000 7 0 0 0 1 06 0000 00000000 00000000 1 00000001 0 0 0 00000000
000 8 0 0 0 1 07 0000 00000000 00000000 1 fffffffd 0 0 0 00000000
000 5 0 0 0 0 00 0000 12345678 00000000 0 00000000 0 0 0 00000000
000 6 0 0 0 0 00 0000 9abcdef0 00000000 0 00000000 0 0 0 00000000
000 7 0 0 0 1 08 0000 00000000 00000000 1 12345678 0 0 0 00000000
000 8 0 0 0 1 09 0000 00000000 00000000 1 9abcdef0 0 0 0 00000000
001 0 1 1 0 0 00 0003 00001000 000000a5 1 00001003 0 0 8 a5a5a5a5
001 0 2 1 0 0 00 0002 00001000 0000beef 1 00001002 0 0 c beefbeef
001 0 3 1 0 0 00 0004 00001000 cafef00d 1 00001004 0 0 f cafef00d
001 0 2 1 0 0 00 0001 00001000 0000beef 1 00001001 0 1 0 00000000
001 0 3 1 0 0 00 0006 00001000 cafef00d 1 00001006 0 1 0 00000000
001 0 4 1 0 1 05 0008 00001000 00000000 1 00001008 0 0 0 00000000
001 0 4 1 0 1 05 000a 00001000 00000000 1 0000100a 0 1 0 00000000
001 0 3 1 1 0 00 0004 7ffffffc 00000011 1 80000000 1 0 0 00000000

// ==== exe_pkg.sv ====
`include "exe_unit_macros.svh"

package exe_pkg;

    typedef logic [`EXE_WORD_W-1:0]   word_t;
    typedef logic [2*`EXE_WORD_W-1:0] dword_t;   // {hi, lo}
    typedef logic [`EXE_REG_W-1:0]    reg_idx_t;
    typedef logic [`EXE_ALU_OP_W-1:0] alu_op_t;

    typedef enum logic [3:0] {
        MD_NONE,
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU,
        MD_MTHI,
        MD_MTLO,
        MD_MFHI,
        MD_MFLO
    } md_op_t;

    // lw only needs the address check and a read request
    typedef enum logic [2:0] {
        ST_NONE,
        ST_SB,
        ST_SH,
        ST_SW,
        LD_LW
    } st_op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage

// ==== exe_stage.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module exe_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              ds_valid,
    output logic              es_allowin,
    input  exe_pkg::alu_op_t  ds_alu_op,
    input  exe_pkg::md_op_t   ds_md_op,
    input  exe_pkg::st_op_t   ds_st_op,
    input  logic              ds_src2_is_imm,
    input  logic              ds_ov_check,
    input  logic              ds_gr_we,
    input  exe_pkg::reg_idx_t ds_dest,
    input  logic [15:0]       ds_imm,
    input  exe_pkg::word_t    ds_rs_value,
    input  exe_pkg::word_t    ds_rt_value,
    input  logic              ms_allowin,
    output logic              es_to_ms_valid,
    output exe_pkg::word_t    es_result,
    output exe_pkg::reg_idx_t es_dest,
    output logic              es_gr_we,
    output logic              es_ov,
    output logic              es_ades,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [3:0]        data_sram_wen,
    output exe_pkg::word_t    data_sram_addr,
    output exe_pkg::word_t    data_sram_wdata,
    input  logic              data_sram_addr_ok
);
    import exe_pkg::*;

    localparam int W = `EXE_WORD_W;

    logic        es_valid;
    logic        es_ready_go;
    logic        es_handoff;
    alu_op_t     es_alu_op;
    md_op_t      es_md_op;
    st_op_t      es_st_op;
    logic        es_src2_is_imm;
    logic        es_ov_check;
    logic [15:0] es_imm;
    word_t       es_rs_value;
    word_t       es_rt_value;
    word_t       alu_src2;
    word_t       alu_result;
    logic        alu_ov;
    dword_t      mul_result;
    dword_t      div_result;
    logic        div_in_valid;
    logic        div_out_valid;
    logic        div_issued;
    logic        is_div;
    logic        is_mem;
    logic        es_exc;
    word_t       hi;
    word_t       lo;

    assign es_handoff     = es_to_ms_valid && ms_allowin;
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            es_alu_op      <= ds_alu_op;
            es_md_op       <= ds_md_op;
            es_st_op       <= ds_st_op;
            es_src2_is_imm <= ds_src2_is_imm;
            es_ov_check    <= ds_ov_check;
            es_gr_we       <= ds_gr_we;
            es_dest        <= ds_dest;
            es_imm         <= ds_imm;
            es_rs_value    <= ds_rs_value;
            es_rt_value    <= ds_rt_value;
        end
    end

    assign is_div = (es_md_op == MD_DIV) || (es_md_op == MD_DIVU);
    assign is_mem = (es_st_op != ST_NONE);

    assign alu_src2 = es_src2_is_imm ? {{(W-16){es_imm[15]}}, es_imm} : es_rt_value;

    alu u_alu (
        .alu_op     (es_alu_op),
        .alu_src1   (es_rs_value),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .alu_ov     (alu_ov)
    );

    multiplier u_multiplier (
        .mul_signed (es_md_op == MD_MULT),
        .mul_src1   (es_rs_value),
        .mul_src2   (es_rt_value),
        .mul_result (mul_result)
    );

    // one issue per divide; cleared when the stage takes its next item
    always_ff @(posedge clk) begin
        if (reset || flush || es_allowin) begin
            div_issued <= 1'b0;
        end else if (div_in_valid) begin
            div_issued <= 1'b1;
        end
    end

    assign div_in_valid = es_valid && is_div && !div_issued;

    divider u_divider (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .div_signed    (es_md_op == MD_DIV),
        .dividend      (es_rs_value),
        .divisor       (es_rt_value),
        .div_in_valid  (div_in_valid),
        .div_out_ready (ms_allowin),
        .div_out_valid (div_out_valid),
        .div_result    (div_result)
    );

    store_unit u_store_unit (
        .st_op    (es_st_op),
        .addr_low (alu_result[1:0]),
        .rt_value (es_rt_value),
        .mem_wen  (data_sram_wen),
        .wdata    (data_sram_wdata),
        .ades     (es_ades)
    );

    assign es_ov  = es_ov_check && alu_ov;
    assign es_exc = es_ov || es_ades;

    assign data_sram_req  = es_valid && is_mem && !es_exc && ms_allowin;
    assign data_sram_wr   = is_mem && (es_st_op != LD_LW);
    assign data_sram_addr = alu_result;

    // faulting memory ops skip the bus and leave at once
    always_comb begin
        if (is_div) begin
            es_ready_go = div_out_valid;
        end else if (is_mem && !es_exc) begin
            es_ready_go = data_sram_req && data_sram_addr_ok;
        end else begin
            es_ready_go = 1'b1;
        end
    end

    // hi/lo commit only when the item leaves clean
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (es_handoff && !es_exc && !flush) begin
            case (es_md_op)
                MD_MULT, MD_MULTU: begin
                    hi <= mul_result[2*W-1:W];
                    lo <= mul_result[W-1:0];
                end
                MD_DIV, MD_DIVU: begin
                    hi <= div_result[2*W-1:W];   // remainder
                    lo <= div_result[W-1:0];     // quotient
                end
                MD_MTHI: hi <= es_rs_value;
                MD_MTLO: lo <= es_rs_value;
                default: begin
                    hi <= hi;
                end
            endcase
        end
    end

    assign es_result = (es_md_op == MD_MFHI) ? hi
                     : (es_md_op == MD_MFLO) ? lo
                     : alu_result;

    // an offered item stays offered until memory takes it
    assert property (@(posedge clk) disable iff (reset || flush)
        es_to_ms_valid && !ms_allowin |=> es_valid && es_to_ms_valid);

endmodule

// ==== exe_unit.f ====
+incdir+.
exe_pkg.sv
alu.sv
multiplier.sv
divider.sv
store_unit.sv
exe_stage.sv
exe_checker.sv
tb_exe_stage.sv

// ==== exe_unit_macros.svh ====
`ifndef EXE_UNIT_MACROS_SVH
`define EXE_UNIT_MACROS_SVH

// datapath word
`define EXE_WORD_W 32

// one bit per alu operation
`define EXE_ALU_OP_W 12

// gpr index
`define EXE_REG_W 5

// shift-subtract steps per divide, one quotient bit each
`define EXE_DIV_CYCLES 32

`endif

// ==== multiplier.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module multiplier (
    input  logic            mul_signed,
    input  exe_pkg::word_t  mul_src1,
    input  exe_pkg::word_t  mul_src2,
    output exe_pkg::dword_t mul_result
);
    localparam int W = `EXE_WORD_W;

    logic signed [W:0]     src1_ext;
    logic signed [W:0]     src2_ext;
    logic signed [2*W+1:0] product;

    // 33-bit operands let one signed multiply cover mult and multu
    assign src1_ext = {mul_signed & mul_src1[W-1], mul_src1};
    assign src2_ext = {mul_signed & mul_src2[W-1], mul_src2};

    assign product = src1_ext * src2_ext;

    assign mul_result = product[2*W-1:0];   // hi in the upper half

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_exe_stage -f exe_unit.f -o sim_exe_unit

out=$(./obj_dir/sim_exe_unit)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All checks passed"

// ==== store_unit.sv ====
`timescale 1ns/100ps

module store_unit (
    input  exe_pkg::st_op_t st_op,
    input  logic [1:0]      addr_low,
    input  exe_pkg::word_t  rt_value,
    output logic [3:0]      mem_wen,
    output exe_pkg::word_t  wdata,
    output logic            ades
);
    import exe_pkg::*;

    logic [3:0] lane_wen;

    always_comb begin
        lane_wen = 4'b0000;
        ades     = 1'b0;
        wdata    = rt_value;
        case (st_op)
            ST_SB: begin
                lane_wen = 4'b0001 << addr_low;
                wdata    = {4{rt_value[7:0]}};    // byte on every lane
            end
            ST_SH: begin
                lane_wen = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata    = {2{rt_value[15:0]}};
                ades     = addr_low[0];
            end
            ST_SW: begin
                lane_wen = 4'b1111;
                ades     = |addr_low;
            end
            LD_LW: begin
                ades = |addr_low;                 // read, no lanes
            end
            default: begin
                lane_wen = 4'b0000;
            end
        endcase
    end

    // misaligned access writes nothing
    assign mem_wen = ades ? 4'b0000 : lane_wen;

endmodule

// ==== tb_exe_stage.sv ====
`timescale 1ns/100ps
`include "exe_unit_macros.svh"

module tb_exe_stage;
    import exe_pkg::*;

    localparam int FIELDS       = 16;
    localparam int MAX_LINES    = 64;
    localparam int RESET_CYCLES = 10;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        ds_valid;
    logic        es_allowin;
    alu_op_t     ds_alu_op;
    md_op_t      ds_md_op;
    st_op_t      ds_st_op;
    logic        ds_src2_is_imm;
    logic        ds_ov_check;
    logic        ds_gr_we;
    reg_idx_t    ds_dest;
    logic [15:0] ds_imm;
    word_t       ds_rs_value;
    word_t       ds_rt_value;
    logic        ms_allowin;
    logic        es_to_ms_valid;
    word_t       es_result;
    reg_idx_t    es_dest;
    logic        es_gr_we;
    logic        es_ov;
    logic        es_ades;
    logic        data_sram_req;
    logic        data_sram_wr;
    logic [3:0]  data_sram_wen;
    word_t       data_sram_addr;
    word_t       data_sram_wdata;
    logic        data_sram_addr_ok;
    logic        chk_done;
    int          chk_errors;
    int          chk_items;
    int          chk_reqs;
    logic [31:0] stim [0:MAX_LINES*FIELDS-1];
    int          n_lines;

    exe_stage DUT (.*);

    exe_checker u_checker (
        .clk (clk), .reset (reset),
        .es_to_ms_valid (es_to_ms_valid), .ms_allowin (ms_allowin),
        .es_result (es_result), .es_dest (es_dest), .es_gr_we (es_gr_we),
        .es_ov (es_ov), .es_ades (es_ades),
        .data_sram_req (data_sram_req), .data_sram_wr (data_sram_wr),
        .data_sram_wen (data_sram_wen), .data_sram_addr (data_sram_addr),
        .data_sram_wdata (data_sram_wdata), .data_sram_addr_ok (data_sram_addr_ok),
        .done (chk_done), .error_count (chk_errors),
        .item_count (chk_items), .req_count (chk_reqs)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic drive_line(input int k);
        ds_valid       <= 1'b1;
        ds_alu_op      <= alu_op_t'(stim[k*FIELDS][`EXE_ALU_OP_W-1:0]);
        ds_md_op       <= md_op_t'(stim[k*FIELDS+1][3:0]);
        ds_st_op       <= st_op_t'(stim[k*FIELDS+2][2:0]);
        ds_src2_is_imm <= stim[k*FIELDS+3][0];
        ds_ov_check    <= stim[k*FIELDS+4][0];
        ds_gr_we       <= stim[k*FIELDS+5][0];
        ds_dest        <= stim[k*FIELDS+6][`EXE_REG_W-1:0];
        ds_imm         <= stim[k*FIELDS+7][15:0];
        ds_rs_value    <= stim[k*FIELDS+8];
        ds_rt_value    <= stim[k*FIELDS+9];
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory side stalls, upper lcg bits only
    initial begin : stall_gen
        logic [31:0] lcg;
        lcg = 32'd6;
        ms_allowin        <= 1'b1;
        data_sram_addr_ok <= 1'b0;
        forever begin
            @(posedge clk);
            lcg = lcg_next(lcg);
            ms_allowin        <= |lcg[30:29];
            data_sram_addr_ok <= |lcg[27:26];
        end
    end

    initial begin : stimulus
        reset          <= 1'b1;
        flush          <= 1'b0;
        ds_valid       <= 1'b0;
        ds_alu_op      <= '0;
        ds_md_op       <= MD_NONE;
        ds_st_op       <= ST_NONE;
        ds_src2_is_imm <= 1'b0;
        ds_ov_check    <= 1'b0;
        ds_gr_we       <= 1'b0;
        ds_dest        <= '0;
        ds_imm         <= '0;
        ds_rs_value    <= '0;
        ds_rt_value    <= '0;
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            stim[i] = 32'h8000_0000 | i;
        end
        $readmemh("exe_input.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && !stim[n_lines*FIELDS][31]) begin
            n_lines++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            drive_line(i);
            @(negedge clk);
            while (!es_allowin) @(negedge clk);   // held until the stage takes it
            @(posedge clk);
        end
        ds_valid <= 1'b0;
    end

    initial begin : run_control
        int cycles;
        int limit;
        cycles = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        limit = n_lines * (`EXE_DIV_CYCLES + 10);
        while (!chk_done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (4) @(posedge clk);   // catch stray hand-offs after the last item
        $display("items %0d of %0d, requests %0d, errors %0d, cycles %0d",
                 chk_items, n_lines, chk_reqs, chk_errors, cycles);
        if (n_lines > 0 && chk_done && chk_errors == 0) begin
            $display("All checks passed");
        end else begin
            if (n_lines == 0) begin
                $display("No stimulus lines were read from exe_input.txt");
            end else if (!chk_done) begin
                $display("Timeout: %0d of %0d items reached memory within %0d cycles",
                         chk_items, n_lines, limit);
            end
            $display("Checks failed");
        end
        $finish;
    end

endmodule
